//--- Makefile
TOP = laser_chaser_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f laser_chaser.f -Mdir obj_dir -o $(TOP)_sim

run: compile
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/laser_chaser_tb.sv
`default_nettype none

`include "laser_chaser_defines.svh"

module laser_chaser_tb import laser_chaser_pkg::*; ();

  localparam int FRAME_WIDTH = `LC_FRAME_WIDTH;
  localparam int FRAME_HEIGHT = `LC_FRAME_HEIGHT;
  localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
  // Two bytes of four cycles each per pixel, plus line blanking and vsync
  localparam int FRAME_CYCLES = FRAME_PIXELS * 8 + FRAME_HEIGHT * 4 + 64;
  localparam int CYCLE_LIMIT = 8 * FRAME_CYCLES + 10000;

  // Red square, inside band 0
  localparam int SQ_TOP = 40;
  localparam int SQ_ROWS = 20;
  localparam int SQ_LEFT = 150;
  localparam int SQ_COLS = 30;

  logic clk_pixel;
  logic rst_in;
  cam_bus_t cam;
  chroma_t chroma_lower_bound;
  chroma_t chroma_upper_bound;
  mask_count_t detection_threshold;
  detect_t detected;
  band_counts_t frame_counts;

  rgb565_t frame_pix [FRAME_PIXELS];

  // Hand-off between stimulus and compare process
  logic check_req;
  band_counts_t exp_counts;
  detect_t exp_detect;
  string test_name;

  int cycle_count;
  int test_count;
  int check_count;
  int error_count;
  int errors_before;

  chroma_t rand_lower;
  chroma_t rand_upper;
  band_counts_t rand_counts;
  band_counts_t square_counts;

  laser_chaser laser_chaser_inst (
    .clk_pixel(clk_pixel),
    .rst_in(rst_in),
    .cam(cam),
    .chroma_lower_bound(chroma_lower_bound),
    .chroma_upper_bound(chroma_upper_bound),
    .detection_threshold(detection_threshold),
    .detected(detected),
    .frame_counts(frame_counts)
  );

  always #2 clk_pixel = ~clk_pixel;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic int cr_of(rgb565_t p);
    int r;
    int g;
    int b;
    int cr;
    r = int'(p[15:11]) * 8;
    g = int'(p[10:5]) * 4;
    b = int'(p[4:0]) * 8;
    cr = 128 + ((128 * r - 107 * g - 21 * b) >>> 8);
    return (cr < 0) ? 0 : ((cr > 255) ? 255 : cr);
  endfunction

  function automatic band_counts_t expected_counts(chroma_t lower, chroma_t upper);
    band_counts_t counts;
    int cr;
    int line;
    counts = '0;
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      cr = cr_of(frame_pix[i]);
      line = i / FRAME_WIDTH;
      for (int b = 0; b < `LC_NUM_BANDS; b++) begin
        if (line >= b * FRAME_HEIGHT / `LC_NUM_BANDS &&
            line < (b + 1) * FRAME_HEIGHT / `LC_NUM_BANDS &&
            cr >= int'(lower) && cr <= int'(upper)) begin
          counts[b] = counts[b] + mask_count_t'(1);
        end
      end
    end
    return counts;
  endfunction

  function automatic detect_t expected_detect(band_counts_t counts, mask_count_t threshold);
    detect_t det;
    for (int b = 0; b < `LC_NUM_BANDS; b++) begin
      det[b] = counts[b] > threshold;
    end
    return det;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Frame contents
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_black();
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      frame_pix[i] = 16'h0000;
    end
  endtask

  task automatic fill_square();
    int row;
    int col;
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      row = i / FRAME_WIDTH;
      col = i % FRAME_WIDTH;
      if (row >= SQ_TOP && row < SQ_TOP + SQ_ROWS &&
          col >= SQ_LEFT && col < SQ_LEFT + SQ_COLS) begin
        frame_pix[i] = 16'hf800;
      end else begin
        frame_pix[i] = 16'h0000;
      end
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      frame_pix[i] = rgb565_t'($urandom);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Camera bus driver
  ////////////////////////////////////////////////////////////////////////////

  // pclk toggles every two clk_pixel cycles
  task automatic send_byte(logic [7:0] value);
    cam.pclk = 1'b0;
    cam.data = value;
    repeat (2) @(negedge clk_pixel);
    cam.pclk = 1'b1;
    repeat (2) @(negedge clk_pixel);
  endtask

  task automatic send_pixel(rgb565_t p);
    send_byte(p[15:8]);
    send_byte(p[7:0]);
  endtask

  // New bounds apply to the new frame, the threshold judges the last one
  task automatic begin_frame(chroma_t lower, chroma_t upper, mask_count_t threshold);
    cam.href = 1'b0;
    repeat (16) @(negedge clk_pixel);
    chroma_lower_bound = lower;
    chroma_upper_bound = upper;
    detection_threshold = threshold;
    cam.vsync = 1'b1;
    repeat (8) @(negedge clk_pixel);
    cam.vsync = 1'b0;
    repeat (8) @(negedge clk_pixel);
    cam.href = 1'b1;
    send_pixel(frame_pix[0]);
    // First pixel reaches the band counters and the resolver
    repeat (16) @(negedge clk_pixel);
  endtask

  task automatic send_rest();
    for (int i = 1; i < FRAME_PIXELS; i++) begin
      if (i % FRAME_WIDTH == 0) begin
        cam.href = 1'b1;
      end
      send_pixel(frame_pix[i]);
      if (i % FRAME_WIDTH == FRAME_WIDTH - 1) begin
        cam.href = 1'b0;
        repeat (4) @(negedge clk_pixel);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_counts(band_counts_t expected, band_counts_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: frame_counts expected %h, actual %h", $time, expected, actual);
    end
  endtask

  task automatic check_detect(detect_t expected, detect_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: detected expected %b, actual %b", $time, expected, actual);
    end
  endtask

  task automatic request_check(string name, band_counts_t counts, detect_t det);
    test_name = name;
    exp_counts = counts;
    exp_detect = det;
    check_req = 1'b1;
    wait (check_req == 1'b0);
  endtask

  always @(negedge clk_pixel) begin
    if (check_req) begin
      errors_before = error_count;
      check_counts(exp_counts, frame_counts);
      check_detect(exp_detect, detected);
      test_count++;
      if (error_count == errors_before) begin
        $display("test %0d, %s: ok", test_count, test_name);
      end else begin
        $display("test %0d, %s: FAILED", test_count, test_name);
      end
      check_req = 1'b0;
    end
  end

  always @(posedge clk_pixel) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_pixel = 1'b0;
    rst_in = 1'b1;
    cam = '0;
    chroma_lower_bound = 8'd160;
    chroma_upper_bound = 8'd255;
    detection_threshold = 16'd100;
    check_req = 1'b0;
    cycle_count = 0;
    test_count = 0;
    check_count = 0;
    error_count = 0;
    void'($urandom(32'h8e7f_5950));

    repeat (16) @(negedge clk_pixel);
    rst_in = 1'b0;
    repeat (4) @(negedge clk_pixel);
    request_check("after reset", '0, '0);

    // Black frame, Cr of 128 sits below the window
    fill_black();
    begin_frame(8'd160, 8'd255, 16'd100);
    send_rest();

    // The square frame's first pixel closes the black frame
    fill_square();
    begin_frame(8'd160, 8'd255, 16'd100);
    request_check("black frame", '0, '0);
    send_rest();

    fill_random();
    rand_lower = chroma_t'($urandom_range(160, 96));
    rand_upper = chroma_t'(int'(rand_lower) + int'($urandom_range(80, 16)));
    rand_counts = expected_counts(rand_lower, rand_upper);
    begin_frame(rand_lower, rand_upper, 16'd100);
    square_counts = '0;
    square_counts[0] = mask_count_t'(SQ_ROWS * SQ_COLS);
    request_check("red square in band 0", square_counts,
                  expected_detect(square_counts, 16'd100));
    send_rest();

    // Same random frame again, judged at two thresholds
    begin_frame(rand_lower, rand_upper, rand_counts[1]);
    request_check("random frame, threshold equal to band 1", rand_counts,
                  expected_detect(rand_counts, rand_counts[1]));
    send_rest();

    begin_frame(rand_lower, rand_upper, rand_counts[1] - mask_count_t'(1));
    request_check("random frame, threshold one below band 1", rand_counts,
                  expected_detect(rand_counts, rand_counts[1] - mask_count_t'(1)));

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/band_counter.sv
`default_nettype none

`include "laser_chaser_defines.svh"

module band_counter import laser_chaser_pkg::*; #(
  parameter int BAND_INDEX = 0
) (
  input wire clk_pixel,
  input wire rst_in,
  input wire masked_pix_t masked,
  output mask_count_t band_count,
  output logic counts_ready
);

  localparam int FIRST_LINE = BAND_INDEX * `LC_FRAME_HEIGHT / `LC_NUM_BANDS;
  localparam int END_LINE = (BAND_INDEX + 1) * `LC_FRAME_HEIGHT / `LC_NUM_BANDS;
  localparam int BAND_PIXELS = (END_LINE - FIRST_LINE) * `LC_FRAME_WIDTH;

  logic in_band;
  logic frame_start;
  mask_count_t total;

  assign in_band = (int'(masked.coord.vcount) >= FIRST_LINE) &&
                   (int'(masked.coord.vcount) < END_LINE);

  // First pixel of a frame closes the previous one
  assign frame_start = masked.coord.valid &&
                       (masked.coord.hcount == '0) && (masked.coord.vcount == '0);

  always_ff @(posedge clk_pixel) begin
    if (rst_in) begin
      total <= '0;
      band_count <= '0;
      counts_ready <= 1'b0;
    end else begin
      counts_ready <= 1'b0;
      if (frame_start) begin
        band_count <= total;
        counts_ready <= 1'b1;
        total <= (in_band && masked.mask) ? mask_count_t'(1) : '0;
      end else if (masked.coord.valid && in_band && masked.mask) begin
        total <= total + mask_count_t'(1);
      end
    end
  end

  // Only holds while frames restart on time
  assert property (@(posedge clk_pixel) disable iff (rst_in)
    int'(total) <= BAND_PIXELS);

endmodule

`default_nettype wire

//--- hdl/camera_capture.sv
`default_nettype none

module camera_capture import laser_chaser_pkg::*; (
  input wire clk_pixel,
  input wire rst_in,
  input wire cam_bus_t cam,
  output rgb565_t pixel,
  output logic pixel_valid,
  output logic frame_done
);

  ////////////////////////////////////////////////////////////////////////////
  // Synchronizers and edge detect
  ////////////////////////////////////////////////////////////////////////////

  cam_bus_t cam_meta;
  cam_bus_t cam_sync;
  logic pclk_prev;
  logic vsync_prev;
  logic pclk_rise;

  always_ff @(posedge clk_pixel) begin
    if (rst_in) begin
      cam_meta <= '0;
      cam_sync <= '0;
      pclk_prev <= 1'b0;
      vsync_prev <= 1'b0;
    end else begin
      cam_meta <= cam;
      cam_sync <= cam_meta;
      pclk_prev <= cam_sync.pclk;
      vsync_prev <= cam_sync.vsync;
    end
  end

  assign pclk_rise = cam_sync.pclk && !pclk_prev;

  ////////////////////////////////////////////////////////////////////////////
  // Byte pairing
  ////////////////////////////////////////////////////////////////////////////

  capture_state_t state;
  logic [7:0] high_byte;

  always_ff @(posedge clk_pixel) begin
    if (rst_in) begin
      state <= CAP_WAIT_LINE;
      pixel_valid <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      pixel_valid <= 1'b0;
      frame_done <= cam_sync.vsync && !vsync_prev;
      if (!cam_sync.href) begin
        state <= CAP_WAIT_LINE;
      end else begin
        case (state)
          CAP_WAIT_LINE: state <= pclk_rise ? CAP_LOW_BYTE : CAP_HIGH_BYTE;
          CAP_HIGH_BYTE: if (pclk_rise) state <= CAP_LOW_BYTE;
          CAP_LOW_BYTE: begin
            if (pclk_rise) begin
              pixel_valid <= 1'b1;
              state <= CAP_HIGH_BYTE;
            end
          end
          default: state <= CAP_WAIT_LINE;
        endcase
      end
    end
  end

  // First byte of a pair is R5 and the top of G6
  always_ff @(posedge clk_pixel) begin
    if (cam_sync.href && pclk_rise) begin
      if (state == CAP_LOW_BYTE) begin
        pixel <= {high_byte, cam_sync.data};
      end else begin
        high_byte <= cam_sync.data;
      end
    end
  end

  // A pixel needs two pclk edges, each at least two cycles apart
  assert property (@(posedge clk_pixel) disable iff (rst_in)
    pixel_valid |=> !pixel_valid);

endmodule

`default_nettype wire

//--- hdl/chroma_mask.sv
`default_nettype none

`include "laser_chaser_defines.svh"

module chroma_mask import laser_chaser_pkg::*; (
  input wire clk_pixel,
  input wire rst_in,
  input wire rgb565_t pixel,
  input wire pix_coord_t coord,
  input wire chroma_t lower_bound,
  input wire chroma_t upper_bound,
  output masked_pix_t masked
);

  // Expanded 8-bit channels
  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;

  assign red = {pixel[15:11], 3'b000};
  assign green = {pixel[10:5], 2'b00};
  assign blue = {pixel[4:0], 3'b000};

  ////////////////////////////////////////////////////////////////////////////
  // Cr pipeline
  ////////////////////////////////////////////////////////////////////////////

  logic signed [17:0] prod_r;
  logic signed [17:0] prod_g;
  logic signed [17:0] prod_b;
  logic signed [17:0] cr_sum;
  logic signed [17:0] cr_biased;
  chroma_t cr_clip;
  chroma_t cr_q;
  logic mask_q;

  // Stage 1, one product per channel
  always_ff @(posedge clk_pixel) begin
    prod_r <= {3'd0, red, 7'd0};
    prod_g <= 18'(green) * 18'd107;
    prod_b <= 18'(blue) * 18'd21;
  end

  // Stage 2
  always_ff @(posedge clk_pixel) begin
    cr_sum <= prod_r - prod_g - prod_b;
  end

  // Offset and saturate to 8 bits
  assign cr_biased = (cr_sum >>> 8) + 18'sd128;

  always_comb begin
    if (cr_biased < 0) begin
      cr_clip = 8'd0;
    end else if (cr_biased > 18'sd255) begin
      cr_clip = 8'd255;
    end else begin
      cr_clip = cr_biased[7:0];
    end
  end

  // Stage 3
  always_ff @(posedge clk_pixel) begin
    cr_q <= cr_clip;
  end

  // Stage 4, inclusive window
  always_ff @(posedge clk_pixel) begin
    mask_q <= (cr_q >= lower_bound) && (cr_q <= upper_bound);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Coordinate delay line
  ////////////////////////////////////////////////////////////////////////////

  pix_coord_t coord_pipe [`LC_MASK_LATENCY];

  always_ff @(posedge clk_pixel) begin
    if (rst_in) begin
      for (int i = 0; i < `LC_MASK_LATENCY; i++) begin
        coord_pipe[i] <= '0;
      end
    end else begin
      coord_pipe[0] <= coord;
      for (int i = 1; i < `LC_MASK_LATENCY; i++) begin
        coord_pipe[i] <= coord_pipe[i-1];
      end
    end
  end

  assign masked = '{coord: coord_pipe[`LC_MASK_LATENCY-1], mask: mask_q};

endmodule

`default_nettype wire

//--- hdl/detect_resolve.sv
`default_nettype none

`include "laser_chaser_defines.svh"

module detect_resolve import laser_chaser_pkg::*; (
  input wire clk_pixel,
  input wire rst_in,
  input wire band_counts_t frame_counts,
  input wire counts_ready,
  input wire mask_count_t detection_threshold,
  output detect_t detected
);

  detect_t over_threshold;

  // Strictly greater, so a count equal to the threshold is no hit
  always_comb begin
    for (int i = 0; i < `LC_NUM_BANDS; i++) begin
      over_threshold[i] = frame_counts[i] > detection_threshold;
    end
  end

  // Result holds for a whole frame
  always_ff @(posedge clk_pixel) begin
    if (rst_in) begin
      detected <= '0;
    end else if (counts_ready) begin
      detected <= over_threshold;
    end
  end

endmodule

`default_nettype wire

//--- hdl/laser_chaser.sv
`default_nettype none

`include "laser_chaser_defines.svh"

module laser_chaser import laser_chaser_pkg::*; (
  input wire clk_pixel,
  input wire rst_in,
  input wire cam_bus_t cam,
  input wire chroma_t chroma_lower_bound,
  input wire chroma_t chroma_upper_bound,
  input wire mask_count_t detection_threshold,
  output detect_t detected,
  output band_counts_t frame_counts
);

  rgb565_t cap_pixel;
  logic cap_valid;
  logic frame_done;
  rgb565_t rec_pixel;
  pix_coord_t coord;
  masked_pix_t masked;
  logic [`LC_NUM_BANDS-1:0] band_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Camera to masked pixels
  ////////////////////////////////////////////////////////////////////////////

  camera_capture camera_capture_inst (
    .clk_pixel(clk_pixel),
    .rst_in(rst_in),
    .cam(cam),
    .pixel(cap_pixel),
    .pixel_valid(cap_valid),
    .frame_done(frame_done)
  );

  pixel_recover pixel_recover_inst (
    .clk_pixel(clk_pixel),
    .rst_in(rst_in),
    .pixel(cap_pixel),
    .pixel_valid(cap_valid),
    .frame_done(frame_done),
    .pixel_out(rec_pixel),
    .coord(coord)
  );

  chroma_mask chroma_mask_inst (
    .clk_pixel(clk_pixel),
    .rst_in(rst_in),
    .pixel(rec_pixel),
    .coord(coord),
    .lower_bound(chroma_lower_bound),
    .upper_bound(chroma_upper_bound),
    .masked(masked)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Band counters and detection
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `LC_NUM_BANDS; i++) begin : g_band
    band_counter #(
      .BAND_INDEX(i)
    ) band_counter_inst (
      .clk_pixel(clk_pixel),
      .rst_in(rst_in),
      .masked(masked),
      .band_count(frame_counts[i]),
      .counts_ready(band_ready[i])
    );
  end

  // Band 0 speaks for all counters
  detect_resolve detect_resolve_inst (
    .clk_pixel(clk_pixel),
    .rst_in(rst_in),
    .frame_counts(frame_counts),
    .counts_ready(band_ready[0]),
    .detection_threshold(detection_threshold),
    .detected(detected)
  );

endmodule

`default_nettype wire

//--- hdl/laser_chaser_defines.svh
`ifndef LASER_CHASER_DEFINES_SVH
`define LASER_CHASER_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Frame geometry
////////////////////////////////////////////////////////////////////////////

// Pixels per line, QVGA
`define LC_FRAME_WIDTH 320
// Lines per frame
`define LC_FRAME_HEIGHT 240

////////////////////////////////////////////////////////////////////////////
// Detection
////////////////////////////////////////////////////////////////////////////

// Horizontal bands, each with its own counter
`define LC_NUM_BANDS 2
// Cycles from pixel_recover output to mask output
`define LC_MASK_LATENCY 4

`endif

//--- hdl/laser_chaser_pkg.sv
`default_nettype none

`include "laser_chaser_defines.svh"

package laser_chaser_pkg;

  // Widths with a meaning
  typedef logic [15:0] rgb565_t;
  typedef logic [8:0] hcount_t;
  typedef logic [7:0] vcount_t;
  typedef logic [7:0] chroma_t;
  typedef logic [15:0] mask_count_t;

  // One count per band, band 0 in the low word
  typedef mask_count_t [`LC_NUM_BANDS-1:0] band_counts_t;
  typedef logic [`LC_NUM_BANDS-1:0] detect_t;

  // Raw camera pins, asynchronous to clk_pixel
  typedef struct packed {
    logic pclk;
    logic vsync;
    logic href;
    logic [7:0] data;
  } cam_bus_t;

  typedef struct packed {
    logic valid;
    hcount_t hcount;
    vcount_t vcount;
  } pix_coord_t;

  typedef struct packed {
    pix_coord_t coord;
    logic mask;
  } masked_pix_t;

  typedef enum logic [1:0] {
    CAP_WAIT_LINE,
    CAP_HIGH_BYTE,
    CAP_LOW_BYTE
  } capture_state_t;

endpackage

`default_nettype wire

//--- hdl/pixel_recover.sv
`default_nettype none

`include "laser_chaser_defines.svh"

module pixel_recover import laser_chaser_pkg::*; (
  input wire clk_pixel,
  input wire rst_in,
  input wire rgb565_t pixel,
  input wire pixel_valid,
  input wire frame_done,
  output rgb565_t pixel_out,
  output pix_coord_t coord
);

  localparam hcount_t LAST_COL = hcount_t'(`LC_FRAME_WIDTH - 1);

  // Position the next valid pixel will take
  hcount_t col;
  vcount_t line;

  always_ff @(posedge clk_pixel) begin
    if (rst_in) begin
      col <= '0;
      line <= '0;
      coord <= '0;
    end else begin
      coord.valid <= pixel_valid;
      coord.hcount <= col;
      coord.vcount <= line;
      if (frame_done) begin
        col <= '0;
        line <= '0;
      end else if (pixel_valid) begin
        if (col == LAST_COL) begin
          col <= '0;
          line <= line + vcount_t'(1);
        end else begin
          col <= col + hcount_t'(1);
        end
      end
    end
  end

  // Pixel data lines up with coord
  always_ff @(posedge clk_pixel) begin
    if (pixel_valid) begin
      pixel_out <= pixel;
    end
  end

  // Catches a camera that sends extra lines or misses vsync
  assert property (@(posedge clk_pixel) disable iff (rst_in)
    coord.valid |-> (int'(coord.hcount) < `LC_FRAME_WIDTH) &&
                    (int'(coord.vcount) < `LC_FRAME_HEIGHT));

endmodule

`default_nettype wire

//--- laser_chaser.f
+incdir+hdl
hdl/laser_chaser_pkg.sv
hdl/camera_capture.sv
hdl/pixel_recover.sv
hdl/chroma_mask.sv
hdl/band_counter.sv
hdl/detect_resolve.sv
hdl/laser_chaser.sv
bench/laser_chaser_tb.sv
